// ==== rtl/rvfiPkg.sv ====
`default_nettype none

// Input side of the converter
// Everything here mirrors what the core puts on its RVFI port
package rvfiPkg;

    ////////////////////////////////////////////////////////////
    // Core dimensions
    ////////////////////////////////////////////////////////////

    // Integer register and CSR data width
    localparam int XLEN = 32;

    // Registers per file, same for integer and FP
    localparam int NUM_REGS = 32;

    // Register index width follows the file depth
    localparam int REG_ADDR_W = $clog2(NUM_REGS);

    // Writeback ports reported per file and per retirement
    localparam int NUM_WRITE_PORTS = 2;

    ////////////////////////////////////////////////////////////
    // RVFI records
    ////////////////////////////////////////////////////////////

    // One retired instruction
    typedef struct packed {
        logic            valid;    // Plain strobe, no back-pressure
        logic [63:0]     order;    // Retirement sequence number
        logic [31:0]     insn;     // Raw instruction word
        logic            trap;
        logic            intr;     // First insn of a trap handler
        logic [1:0]      mode;     // Privilege level at retirement
        logic [XLEN-1:0] pcRdata;  // PC of the retired insn
    } retire_t;

    // One CSR as reported at retirement
    // Bits under wmask come from wdata, the rest from rdata
    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] wmask;
    } csrPort_t;

    // One register write port
    typedef struct packed {
        logic                  wvalid;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } regWrite_t;

endpackage

`default_nettype wire

// ==== rtl/rvviPkg.sv ====
`default_nettype none

// Output side of the converter
// Trace record handed to the reference-model comparison
package rvviPkg;

    ////////////////////////////////////////////////////////////
    // CSR set carried by the trace
    ////////////////////////////////////////////////////////////

    // Index of each CSR inside the trace arrays
    localparam int IDX_MSTATUS  = 0;
    localparam int IDX_MISA     = 1;
    localparam int IDX_MIE      = 2;
    localparam int IDX_MTVEC    = 3;
    localparam int IDX_MSCRATCH = 4;
    localparam int IDX_MEPC     = 5;
    localparam int IDX_MCAUSE   = 6;
    localparam int IDX_MIP      = 7;

    // The last index closes the set
    localparam int NUM_CSRS = IDX_MIP + 1;

    // Architectural CSR address width
    localparam int CSR_ADDR_W = 12;

    // Machine-mode addresses, in index order
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR [NUM_CSRS] = '{
        IDX_MSTATUS:  12'h300,
        IDX_MISA:     12'h301,
        IDX_MIE:      12'h304,
        IDX_MTVEC:    12'h305,
        IDX_MSCRATCH: 12'h340,
        IDX_MEPC:     12'h341,
        IDX_MCAUSE:   12'h342,
        IDX_MIP:      12'h344
    };

    ////////////////////////////////////////////////////////////
    // Views and trace
    ////////////////////////////////////////////////////////////

    // Rebuilt CSR values plus one written flag per CSR
    typedef struct packed {
        logic [NUM_CSRS-1:0][rvfiPkg::XLEN-1:0] value;
        logic [NUM_CSRS-1:0]                    wb;
    } csrView_t;

    // Full shadow of one register file plus writeback mask
    typedef struct packed {
        logic [rvfiPkg::NUM_REGS-1:0][rvfiPkg::XLEN-1:0] wdata;
        logic [rvfiPkg::NUM_REGS-1:0]                    wb;
    } regView_t;

    // One trace entry per cycle, valid marks a retirement
    typedef struct packed {
        logic                     valid;
        logic [63:0]              order;
        logic [31:0]              insn;
        logic                     trap;
        logic                     intr;
        logic [1:0]               mode;
        logic [rvfiPkg::XLEN-1:0] pcRdata;
        csrView_t                 csr;
        regView_t                 x;     // Integer file
        regView_t                 f;     // Floating-point file
    } rvviTrace_t;

endpackage

`default_nettype wire

// ==== rtl/csrView.sv ====
`default_nettype none
`timescale 1ns/10ps

// CSR view of the trace
// Rebuilds each CSR from the RVFI masked read/write data and
// flags the ones whose value moved since they were last reported
module csrView (
    input  wire logic              rvvi,
    input  wire logic              reset_i,
    input  wire rvfiPkg::csrPort_t csr_i [rvviPkg::NUM_CSRS],
    input  wire logic              retireValid_i,
    output rvviPkg::csrView_t      view_o
);

    ////////////////////////////////////////////////////////////
    // Merge and compare
    ////////////////////////////////////////////////////////////

    // Value each CSR holds after the retiring insn
    logic [rvviPkg::NUM_CSRS-1:0][rvfiPkg::XLEN-1:0] merged;

    // Value last put on the trace, one per CSR
    logic [rvviPkg::NUM_CSRS-1:0][rvfiPkg::XLEN-1:0] lastValue;

    // Merged value differs from the reported one
    logic [rvviPkg::NUM_CSRS-1:0]                    changed;

    // Registered written flags
    logic [rvviPkg::NUM_CSRS-1:0]                    wbQ;

    always_comb begin
        for (int i = 0; i < rvviPkg::NUM_CSRS; i++) begin
            // Written bits from wdata, untouched bits from rdata
            merged[i] = (csr_i[i].wdata & csr_i[i].wmask)
                      | (csr_i[i].rdata & ~csr_i[i].wmask);
            changed[i] = (merged[i] != lastValue[i]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered view
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rvvi) begin
        if (reset_i) begin
            lastValue <= '0;
            wbQ       <= '0;
        end else if (retireValid_i) begin
            // Report the new value and remember it for next time
            lastValue <= merged;
            wbQ       <= changed;
        end else begin
            // Without a retirement values hold and nothing is flagged
            wbQ <= '0;
        end
    end

    // The reported value is the last-reported register itself
    assign view_o = '{value: lastValue, wb: wbQ};

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // A bubble on the retirement strobe never reports a write
    assert property (@(posedge rvvi) disable iff (reset_i)
        !retireValid_i |=> (view_o.wb == '0))
        else $error("csrView wb set after a cycle without retirement");

endmodule

`default_nettype wire

// ==== rtl/regShadow.sv ====
`default_nettype none
`timescale 1ns/10ps

// Shadow of one register file
// Applies the retirement's write ports to a full copy of the file
// and reports which entries the retirement touched
module regShadow #(
    // Register 0 reads as zero and ignores writes
    parameter bit ZeroWired = 1'b1
) (
    input  wire logic               rvvi,
    input  wire logic               reset_i,
    input  wire rvfiPkg::regWrite_t write_i [rvfiPkg::NUM_WRITE_PORTS],
    input  wire logic               retireValid_i,
    output rvviPkg::regView_t       view_o
);

    ////////////////////////////////////////////////////////////
    // Next-state of the shadow
    ////////////////////////////////////////////////////////////

    logic [rvfiPkg::NUM_REGS-1:0][rvfiPkg::XLEN-1:0] shadow;
    logic [rvfiPkg::NUM_REGS-1:0][rvfiPkg::XLEN-1:0] shadowNext;
    logic [rvfiPkg::NUM_REGS-1:0]                    wbMask;
    logic [rvfiPkg::NUM_REGS-1:0]                    wbNext;

    // Per-port write enable after the register 0 rule
    logic [rvfiPkg::NUM_WRITE_PORTS-1:0]             portWrite;

    always_comb begin
        shadowNext = shadow;
        wbNext     = '0;
        // Ports in ascending order so the higher port wins a collision
        for (int p = 0; p < rvfiPkg::NUM_WRITE_PORTS; p++) begin
            portWrite[p] = write_i[p].wvalid
                         && !(ZeroWired && (write_i[p].addr == '0));
            if (portWrite[p]) begin
                shadowNext[write_i[p].addr] = write_i[p].wdata;
                wbNext[write_i[p].addr]     = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Shadow registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rvvi) begin
        if (reset_i) begin
            shadow <= '0;
            wbMask <= '0;
        end else if (retireValid_i) begin
            shadow <= shadowNext;
            wbMask <= wbNext;
        end else begin
            // Ports are ignored without a retirement
            wbMask <= '0;
        end
    end

    assign view_o = '{wdata: shadow, wb: wbMask};

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    if (ZeroWired) begin : gZeroReg
        // x0 stays zero through any write history
        assert property (@(posedge rvvi) disable iff (reset_i)
            (view_o.wdata[0] == '0) && !view_o.wb[0])
            else $error("regShadow register 0 written in a zero-wired file");
    end

endmodule

`default_nettype wire

// ==== rtl/traceAssembler.sv ====
`default_nettype none
`timescale 1ns/10ps

// Trace assembly
// The views arrive one cycle after their retirement, so the
// retirement record is delayed to meet them and the merged entry
// is registered once more on the way out
module traceAssembler (
    input  wire logic              rvvi,
    input  wire logic              reset_i,
    input  wire rvfiPkg::retire_t  retire_i,
    input  wire rvviPkg::csrView_t csrView_i,
    input  wire rvviPkg::regView_t xView_i,
    input  wire rvviPkg::regView_t fView_i,
    output rvviPkg::rvviTrace_t    trace_o
);

    ////////////////////////////////////////////////////////////
    // Alignment stage
    ////////////////////////////////////////////////////////////

    // Retirement record delayed to the age of the views
    rvfiPkg::retire_t retireQ;

    always_ff @(posedge rvvi) begin
        if (reset_i) begin
            retireQ <= '0;
        end else begin
            retireQ <= retire_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rvvi) begin
        if (reset_i) begin
            trace_o <= '0;
        end else begin
            trace_o.valid   <= retireQ.valid;
            trace_o.order   <= retireQ.order;
            trace_o.insn    <= retireQ.insn;
            trace_o.trap    <= retireQ.trap;
            trace_o.intr    <= retireQ.intr;
            trace_o.mode    <= retireQ.mode;
            trace_o.pcRdata <= retireQ.pcRdata;
            // Views already carry zero masks on idle cycles
            trace_o.csr     <= csrView_i;
            trace_o.x       <= xView_i;
            trace_o.f       <= fView_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Back-to-back retirements leave in program order
    assert property (@(posedge rvvi) disable iff (reset_i)
        (trace_o.valid && $past(trace_o.valid))
            |-> (trace_o.order > $past(trace_o.order)))
        else $error("traceAssembler order did not increase");

endmodule

`default_nettype wire

// ==== rtl/rvfiToRvvi.sv ====
`default_nettype none
`timescale 1ns/10ps

// RVFI to RVVI trace converter
// CSR view and both register shadows run side by side, the
// assembler lines their results up with the retirement record
module rvfiToRvvi (
    input  wire logic               rvvi,
    input  wire logic               reset_i,
    input  wire rvfiPkg::retire_t   retire_i,
    input  wire rvfiPkg::csrPort_t  csr_i    [rvviPkg::NUM_CSRS],
    input  wire rvfiPkg::regWrite_t xWrite_i [rvfiPkg::NUM_WRITE_PORTS],
    input  wire rvfiPkg::regWrite_t fWrite_i [rvfiPkg::NUM_WRITE_PORTS],
    output rvviPkg::rvviTrace_t     trace_o
);

    ////////////////////////////////////////////////////////////
    // Views, one cycle after the retirement
    ////////////////////////////////////////////////////////////

    // Retirement strobe shared by all three views
    logic              retireValid;
    rvviPkg::csrView_t csrView;
    rvviPkg::regView_t xView;
    rvviPkg::regView_t fView;

    assign retireValid = retire_i.valid;

    csrView u_csrView (
        .rvvi          (rvvi),
        .reset_i       (reset_i),
        .csr_i         (csr_i),
        .retireValid_i (retireValid),
        .view_o        (csrView)
    );

    // Integer file, x0 hard-wired
    regShadow #(.ZeroWired(1'b1)) u_xShadow (
        .rvvi          (rvvi),
        .reset_i       (reset_i),
        .write_i       (xWrite_i),
        .retireValid_i (retireValid),
        .view_o        (xView)
    );

    // Floating-point file, f0 is an ordinary register
    regShadow #(.ZeroWired(1'b0)) u_fShadow (
        .rvvi          (rvvi),
        .reset_i       (reset_i),
        .write_i       (fWrite_i),
        .retireValid_i (retireValid),
        .view_o        (fView)
    );

    // Second stage joins record and views
    traceAssembler u_traceAssembler (
        .rvvi      (rvvi),
        .reset_i   (reset_i),
        .retire_i  (retire_i),
        .csrView_i (csrView),
        .xView_i   (xView),
        .fView_i   (fView),
        .trace_o   (trace_o)
    );

endmodule

`default_nettype wire

// ==== verif/tbRvfiToRvvi.sv ====
`default_nettype none
`timescale 1ns/10ps

// Testbench for the RVFI to RVVI converter
// Random retirements go in, a model in the testbench predicts each trace entry
module tbRvfiToRvvi;

    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 8;
    localparam int NUM_RETIRE    = 400;
    localparam int RUN_TIMEOUT   = 4000;

    logic                rvvi;
    logic                reset_i;
    rvfiPkg::retire_t    retireIn;
    rvfiPkg::csrPort_t   csrIn    [rvviPkg::NUM_CSRS];
    rvfiPkg::regWrite_t  xWriteIn [rvfiPkg::NUM_WRITE_PORTS];
    rvfiPkg::regWrite_t  fWriteIn [rvfiPkg::NUM_WRITE_PORTS];
    rvviPkg::rvviTrace_t traceOut;

    // Model state and the two-deep expectation pipe
    logic [31:0]         rngState;
    logic [63:0]         orderNext;
    rvviPkg::csrView_t   csrModel;
    rvviPkg::regView_t   xModel;
    rvviPkg::regView_t   fModel;
    rvviPkg::rvviTrace_t expNow;
    rvviPkg::rvviTrace_t expPipe [2];
    int                  issued;
    int                  checked;
    int                  runCycles;
    int                  resetCycles;

    rvfiToRvvi u_dut (
        .rvvi     (rvvi),
        .reset_i  (reset_i),
        .retire_i (retireIn),
        .csr_i    (csrIn),
        .xWrite_i (xWriteIn),
        .fWrite_i (fWriteIn),
        .trace_o  (traceOut)
    );

    initial rvvi = 1'b0;
    always #5 rvvi = ~rvvi;

    ////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////

    task automatic stopOnFailure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic valueError(input string name, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        stopOnFailure($sformatf("error %s expected %h actual %h", name, expVal, actVal));
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Xorshift32 step, state lives in rngState
    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // CSR addresses as the trace format defines them
    function automatic logic [11:0] expectedCsrAddr(input int idx);
        case (idx)
            0:       return 12'h300;
            1:       return 12'h301;
            2:       return 12'h304;
            3:       return 12'h305;
            4:       return 12'h340;
            5:       return 12'h341;
            6:       return 12'h342;
            default: return 12'h344;
        endcase
    endfunction

    // Two ports, addresses sometimes collide or hit register 0
    task automatic randomWrites(output rvfiPkg::regWrite_t p0, output rvfiPkg::regWrite_t p1);
        logic [31:0] r;
        r = nextRand();
        p0.wvalid = r[0];
        p1.wvalid = r[1];
        p0.addr   = r[8:4];
        p1.addr   = r[16:12];
        if (r[19:18] == 2'd0) p1.addr = p0.addr;
        if (r[22:20] == 3'd0) p0.addr = '0;
        if (r[25:23] == 3'd0) p1.addr = '0;
        p0.wdata  = nextRand();
        p1.wdata  = nextRand();
    endtask

    task automatic driveInputs(input logic allowValid);
        logic [31:0] r;
        r = nextRand();
        // 90 of 128 is roughly 70 percent
        retireIn.valid   = allowValid && (r[6:0] < 7'd90);
        retireIn.order   = orderNext;
        retireIn.trap    = r[8];
        retireIn.intr    = r[9];
        retireIn.mode    = r[11:10];
        retireIn.insn    = nextRand();
        retireIn.pcRdata = nextRand();
        if (retireIn.valid) orderNext = orderNext + 64'd1;
        for (int i = 0; i < rvviPkg::NUM_CSRS; i++) begin
            r = nextRand();
            csrIn[i].wdata = nextRand();
            if (r[1:0] == 2'd0) begin
                // Unchanged CSR, so the written flag stays clear
                csrIn[i].wmask = '0;
                csrIn[i].rdata = csrModel.value[i];
            end else begin
                csrIn[i].wmask = nextRand();
                csrIn[i].rdata = nextRand();
            end
        end
        randomWrites(xWriteIn[0], xWriteIn[1]);
        randomWrites(fWriteIn[0], fWriteIn[1]);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Ports in order, a later write to the same entry overwrites
    function automatic rvviPkg::regView_t updateFile(input rvviPkg::regView_t prev,
            input bit zeroWired, input logic valid,
            input rvfiPkg::regWrite_t w0, input rvfiPkg::regWrite_t w1);
        rvviPkg::regView_t nv;
        nv    = prev;
        nv.wb = '0;
        if (valid && w0.wvalid && !(zeroWired && w0.addr == 5'd0)) begin
            nv.wdata[w0.addr] = w0.wdata;
            nv.wb[w0.addr]    = 1'b1;
        end
        if (valid && w1.wvalid && !(zeroWired && w1.addr == 5'd0)) begin
            nv.wdata[w1.addr] = w1.wdata;
            nv.wb[w1.addr]    = 1'b1;
        end
        return nv;
    endfunction

    task automatic applyModel();
        logic [31:0] merged;
        csrModel.wb = '0;
        if (retireIn.valid) begin
            for (int i = 0; i < rvviPkg::NUM_CSRS; i++) begin
                merged = (csrIn[i].wdata & csrIn[i].wmask) | (csrIn[i].rdata & ~csrIn[i].wmask);
                csrModel.wb[i]    = (merged != csrModel.value[i]);
                csrModel.value[i] = merged;
            end
        end
        xModel = updateFile(xModel, 1'b1, retireIn.valid, xWriteIn[0], xWriteIn[1]);
        fModel = updateFile(fModel, 1'b0, retireIn.valid, fWriteIn[0], fWriteIn[1]);
        expNow.valid   = retireIn.valid;
        expNow.order   = retireIn.order;
        expNow.insn    = retireIn.insn;
        expNow.trap    = retireIn.trap;
        expNow.intr    = retireIn.intr;
        expNow.mode    = retireIn.mode;
        expNow.pcRdata = retireIn.pcRdata;
        expNow.csr     = csrModel;
        expNow.x       = xModel;
        expNow.f       = fModel;
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic checkIdle();
        assert (!traceOut.valid) else valueError("trace_o.valid", 64'd0, 64'(traceOut.valid));
        assert (traceOut.csr.wb == '0) else valueError("trace_o.csr.wb", 64'd0, 64'(traceOut.csr.wb));
        assert (traceOut.x.wb == '0) else valueError("trace_o.x.wb", 64'd0, 64'(traceOut.x.wb));
        assert (traceOut.f.wb == '0) else valueError("trace_o.f.wb", 64'd0, 64'(traceOut.f.wb));
    endtask

    task automatic checkTrace(input rvviPkg::rvviTrace_t exp);
        assert (traceOut.valid == exp.valid)
            else valueError("trace_o.valid", 64'(exp.valid), 64'(traceOut.valid));
        // Retirement fields only carry meaning on a valid entry
        if (exp.valid) begin
            assert (traceOut.order == exp.order)
                else valueError("trace_o.order", exp.order, traceOut.order);
            assert (traceOut.insn == exp.insn)
                else valueError("trace_o.insn", 64'(exp.insn), 64'(traceOut.insn));
            assert (traceOut.trap == exp.trap)
                else valueError("trace_o.trap", 64'(exp.trap), 64'(traceOut.trap));
            assert (traceOut.intr == exp.intr)
                else valueError("trace_o.intr", 64'(exp.intr), 64'(traceOut.intr));
            assert (traceOut.mode == exp.mode)
                else valueError("trace_o.mode", 64'(exp.mode), 64'(traceOut.mode));
            assert (traceOut.pcRdata == exp.pcRdata)
                else valueError("trace_o.pcRdata", 64'(exp.pcRdata), 64'(traceOut.pcRdata));
        end
        for (int i = 0; i < rvviPkg::NUM_CSRS; i++) begin
            assert (traceOut.csr.value[i] == exp.csr.value[i])
                else valueError($sformatf("trace_o.csr.value[%0d]", i),
                                64'(exp.csr.value[i]), 64'(traceOut.csr.value[i]));
        end
        assert (traceOut.csr.wb == exp.csr.wb)
            else valueError("trace_o.csr.wb", 64'(exp.csr.wb), 64'(traceOut.csr.wb));
        for (int r = 0; r < rvfiPkg::NUM_REGS; r++) begin
            assert (traceOut.x.wdata[r] == exp.x.wdata[r])
                else valueError($sformatf("trace_o.x.wdata[%0d]", r),
                                64'(exp.x.wdata[r]), 64'(traceOut.x.wdata[r]));
            assert (traceOut.f.wdata[r] == exp.f.wdata[r])
                else valueError($sformatf("trace_o.f.wdata[%0d]", r),
                                64'(exp.f.wdata[r]), 64'(traceOut.f.wdata[r]));
        end
        assert (traceOut.x.wb == exp.x.wb)
            else valueError("trace_o.x.wb", 64'(exp.x.wb), 64'(traceOut.x.wb));
        assert (traceOut.f.wb == exp.f.wb)
            else valueError("trace_o.f.wb", 64'(exp.f.wb), 64'(traceOut.f.wb));
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset_i   = 1'b1;
        retireIn  = '0;
        for (int i = 0; i < rvviPkg::NUM_CSRS; i++) csrIn[i] = '0;
        for (int p = 0; p < rvfiPkg::NUM_WRITE_PORTS; p++) begin
            xWriteIn[p] = '0;
            fWriteIn[p] = '0;
        end
        rngState    = 32'hf370;
        orderNext   = 64'd1;
        csrModel    = '0;
        xModel      = '0;
        fModel      = '0;
        expNow      = '0;
        expPipe[0]  = '0;
        expPipe[1]  = '0;
        issued      = 0;
        checked     = 0;
        runCycles   = 0;
        resetCycles = 0;

        for (int i = 0; i < rvviPkg::NUM_CSRS; i++) begin
            assert (rvviPkg::CSR_ADDR[i] == expectedCsrAddr(i))
                else valueError($sformatf("CSR_ADDR[%0d]", i),
                                64'(expectedCsrAddr(i)), 64'(rvviPkg::CSR_ADDR[i]));
        end

        // Wait for reset to clear the trace register
        while (traceOut !== '0) begin
            if (resetCycles >= RESET_TIMEOUT) begin
                stopOnFailure("trace output was not cleared while reset was held");
            end
            @(posedge rvvi);
            #1;
            resetCycles++;
        end
        // Hold reset for the rest of the reset window
        while (resetCycles < RESET_CYCLES) begin
            @(posedge rvvi);
            #1;
            resetCycles++;
            checkIdle();
        end

        // Nothing retires in the first two cycles after reset
        while (checked < NUM_RETIRE) begin
            if (runCycles >= RUN_TIMEOUT) begin
                stopOnFailure("run loop timed out before all retirements came out");
            end
            @(negedge rvvi);
            reset_i = 1'b0;
            driveInputs((runCycles >= 2) && (issued < NUM_RETIRE));
            if (retireIn.valid) issued++;
            applyModel();
            expPipe[1] = expPipe[0];
            expPipe[0] = expNow;
            @(posedge rvvi);
            #1;
            checkTrace(expPipe[1]);
            if (runCycles < 2) checkIdle();
            if (expPipe[1].valid) checked++;
            runCycles++;
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/rvfiPkg.sv
rtl/rvviPkg.sv
rtl/csrView.sv
rtl/regShadow.sv
rtl/traceAssembler.sv
rtl/rvfiToRvvi.sv
verif/tbRvfiToRvvi.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module tbRvfiToRvvi -Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
